// File: source/xt_map_pkg.sv
// XT chipset address map
// Memory regions, I/O chip groups, PPI register numbers and the
// bus address union that gives the memory and I/O views of one address

`default_nettype none

package xt_map_pkg;

    localparam int ADDR_W = 20;
    localparam int DATA_W = 8;

    // Memory regions are 64 KB blocks selected by the top nibble
    localparam logic [3:0] RAM_REGION_MAX = 4'd3;
    localparam logic [3:0] ROM_REGION     = 4'd15;

    // 32-port chip groups inside the 0x000-0x0FF chipset page
    localparam logic [2:0] IO_GROUP_DMA      = 3'd0;
    localparam logic [2:0] IO_GROUP_PPI      = 3'd3;
    localparam logic [2:0] IO_GROUP_DMA_PAGE = 3'd4;

    // PPI registers at 0x60 and 0x61
    localparam logic [1:0] PORT_KEYCODE_REG = 2'd0;
    localparam logic [1:0] PORT_CONTROL_REG = 2'd1;

    localparam logic [7:0] IDLE_READ_DATA = 8'hFF;

    typedef union packed {
        struct packed {
            logic [3:0]  region;
            logic [15:0] offset;
        } mem;
        struct packed {
            logic [9:0] upper;
            logic [1:0] page;
            logic [2:0] group;
            logic [4:0] reg_num;
        } io;
    } bus_addr_u;

endpackage

`default_nettype wire

// File: source/xt_dev_pkg.sv
// XT on-board device parameters
// Memory sizes, download port width, synchronizer depth and the
// port B reset value and bit assignment

`default_nettype none

package xt_dev_pkg;

    // 256 KB system RAM, 64 KB BIOS ROM
    localparam int RAM_ADDR_W = 18;
    localparam int ROM_ADDR_W = 16;

    // Only the low ROM_ADDR_W bits of the download address reach the ROM
    localparam int DL_ADDR_W = 25;

    localparam int SYNC_STAGES = 2;

    localparam logic [7:0] PORT_B_RESET = 8'h00;

    // Port B bits
    localparam logic [2:0] SPK_GATE_BIT  = 3'd0;
    localparam logic [2:0] SPK_DATA_BIT  = 3'd1;
    localparam logic [2:0] KBD_CLEAR_BIT = 3'd7;

endpackage

`default_nettype wire

// File: source/xt_bus_control.sv
// XT bus control
// Decodes memory regions and I/O chip groups, generates the write
// enables and selects what the chipset drives onto the read bus

`timescale 1ns/10ps
`default_nettype none

module xt_bus_control (
    input  wire logic [xt_map_pkg::ADDR_W-1:0] address_i,
    input  wire logic                          io_read_n_i,
    input  wire logic                          io_write_n_i,
    input  wire logic                          memory_read_n_i,
    input  wire logic                          memory_write_n_i,
    input  wire logic                          address_enable_n_i,
    input  wire logic [xt_map_pkg::DATA_W-1:0] ram_data_i,
    input  wire logic [xt_map_pkg::DATA_W-1:0] rom_data_i,
    input  wire logic [xt_map_pkg::DATA_W-1:0] port_b_i,
    input  wire logic [xt_map_pkg::DATA_W-1:0] keycode_i,
    output logic                               ram_write_o,
    output logic                               rom_select_o,
    output logic                               port_b_write_o,
    output logic                               dma_chip_select_n_o,
    output logic                               dma_page_chip_select_n_o,
    output logic      [xt_map_pkg::DATA_W-1:0] data_bus_out_o,
    output logic                               data_bus_out_from_chipset_o
);

    xt_map_pkg::bus_addr_u bus_addr;

    logic       io_select;
    logic       ppi_select;
    logic       ram_select;
    logic       rom_select;
    logic [1:0] ppi_reg;

    assign bus_addr = address_i;

    // Chipset I/O lives in 0x000-0x0FF and only while the CPU owns the bus
    assign io_select  = ~address_enable_n_i & (bus_addr.io.page == 2'b00);
    assign ppi_select = io_select & (bus_addr.io.group == xt_map_pkg::IO_GROUP_PPI);
    assign ppi_reg    = bus_addr.io.reg_num[1:0];

    assign dma_chip_select_n_o =
        ~(io_select & (bus_addr.io.group == xt_map_pkg::IO_GROUP_DMA));
    assign dma_page_chip_select_n_o =
        ~(io_select & (bus_addr.io.group == xt_map_pkg::IO_GROUP_DMA_PAGE));

    // RAM covers regions 0-3, the BIOS region F
    assign ram_select = (bus_addr.mem.region <= xt_map_pkg::RAM_REGION_MAX);
    assign rom_select = (bus_addr.mem.region == xt_map_pkg::ROM_REGION);

    assign ram_write_o    = ram_select & ~memory_write_n_i;
    assign rom_select_o   = rom_select;
    assign port_b_write_o = ppi_select & ~io_write_n_i &
                            (ppi_reg == xt_map_pkg::PORT_CONTROL_REG);

    always_comb begin
        if (ppi_select && !io_read_n_i) begin
            data_bus_out_from_chipset_o = 1'b1;
            case (ppi_reg)
                xt_map_pkg::PORT_KEYCODE_REG: data_bus_out_o = keycode_i;
                xt_map_pkg::PORT_CONTROL_REG: data_bus_out_o = port_b_i;
                default:                      data_bus_out_o = xt_map_pkg::IDLE_READ_DATA;
            endcase
        end
        else if (rom_select && !memory_read_n_i) begin
            data_bus_out_from_chipset_o = 1'b1;
            data_bus_out_o              = rom_data_i;
        end
        else if (ram_select && !memory_read_n_i) begin
            data_bus_out_from_chipset_o = 1'b1;
            data_bus_out_o              = ram_data_i;
        end
        else begin
            data_bus_out_from_chipset_o = 1'b0;
            data_bus_out_o              = '0;
        end
    end

endmodule

`default_nettype wire

// File: source/xt_system_ram.sv
// XT system RAM
// 256 KB byte-wide array, write on strobe, read through a registered address

`timescale 1ns/10ps
`default_nettype none

module xt_system_ram (
    input  wire logic                              clock,
    input  wire logic                              write_i,
    input  wire logic [xt_dev_pkg::RAM_ADDR_W-1:0] address_i,
    input  wire logic [xt_map_pkg::DATA_W-1:0]     data_i,
    output logic      [xt_map_pkg::DATA_W-1:0]     data_o
);

    logic [xt_map_pkg::DATA_W-1:0]     mem [2**xt_dev_pkg::RAM_ADDR_W];
    logic [xt_dev_pkg::RAM_ADDR_W-1:0] read_addr_q;

    always_ff @(posedge clock) begin
        if (write_i) begin
            mem[address_i] <= data_i;
        end
        read_addr_q <= address_i;
    end

    // Data follows the address sampled at the previous edge
    assign data_o = mem[read_addr_q];

endmodule

`default_nettype wire

// File: source/xt_bios_rom.sv
// XT BIOS ROM
// 64 KB array loaded by the download host, read by the CPU at F0000-FFFFF

`timescale 1ns/10ps
`default_nettype none

module xt_bios_rom (
    input  wire logic                              clock,
    input  wire logic                              select_i,
    input  wire logic [xt_dev_pkg::ROM_ADDR_W-1:0] address_i,
    input  wire logic                              ioctl_download_i,
    input  wire logic                              ioctl_wr_i,
    input  wire logic [xt_dev_pkg::DL_ADDR_W-1:0]  ioctl_addr_i,
    input  wire logic [xt_map_pkg::DATA_W-1:0]     ioctl_data_i,
    output logic      [xt_map_pkg::DATA_W-1:0]     data_o
);

    logic [xt_map_pkg::DATA_W-1:0]     mem [2**xt_dev_pkg::ROM_ADDR_W];
    logic [xt_dev_pkg::ROM_ADDR_W-1:0] download_addr;
    logic [xt_dev_pkg::ROM_ADDR_W-1:0] read_addr_q;

    assign download_addr = ioctl_addr_i[xt_dev_pkg::ROM_ADDR_W-1:0];

    always_ff @(posedge clock) begin
        if (ioctl_download_i) begin
            // Download owns the port, CPU reads are locked out
            if (ioctl_wr_i) begin
                mem[download_addr] <= ioctl_data_i;
            end
            read_addr_q <= download_addr;
        end
        else if (select_i) begin
            read_addr_q <= address_i;
        end
    end

    assign data_o = mem[read_addr_q];

endmodule

`default_nettype wire

// File: source/xt_system_port.sv
// XT port B control register at 0x61
// Holds speaker gate and data and the keyboard clear request

`timescale 1ns/10ps
`default_nettype none

module xt_system_port (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          write_i,
    input  wire logic [xt_map_pkg::DATA_W-1:0] data_i,
    output logic      [xt_map_pkg::DATA_W-1:0] port_b_o,
    output logic                               speaker_gate_o,
    output logic                               speaker_data_o,
    output logic                               keyboard_clear_o
);

    logic [xt_map_pkg::DATA_W-1:0] port_b_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            port_b_q <= xt_dev_pkg::PORT_B_RESET;
        end
        else if (write_i) begin
            port_b_q <= data_i;
        end
    end

    assign port_b_o = port_b_q;

    // Bit 0 gates timer 2, bit 1 enables the speaker output
    assign speaker_gate_o = port_b_q[xt_dev_pkg::SPK_GATE_BIT];
    assign speaker_data_o = port_b_q[xt_dev_pkg::SPK_DATA_BIT];

    // Bit 7 holds the keyboard latch in clear
    assign keyboard_clear_o = port_b_q[xt_dev_pkg::KBD_CLEAR_BIT];

endmodule

`default_nettype wire

// File: source/xt_keyboard_latch.sv
// XT keyboard latch
// Synchronizes the asynchronous scan code and request, latches the code
// on a request edge and raises the keyboard interrupt until cleared

`timescale 1ns/10ps
`default_nettype none

module xt_keyboard_latch (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic [xt_map_pkg::DATA_W-1:0] keycode_i,
    input  wire logic                          keyboard_irq_i,
    input  wire logic                          clear_i,
    output logic      [xt_map_pkg::DATA_W-1:0] keycode_o,
    output logic                               interrupt_o
);

    localparam int LAST = xt_dev_pkg::SYNC_STAGES - 1;

    logic [LAST:0]                           irq_sync;
    logic [LAST:0][xt_map_pkg::DATA_W-1:0]   code_sync;
    logic                                    irq_prev;
    logic                                    irq_rise;
    logic [xt_map_pkg::DATA_W-1:0]           keycode_q;
    logic                                    interrupt_q;

    // Code runs through the same depth, so it is settled when the edge arrives
    always_ff @(posedge clock) begin
        code_sync <= {code_sync[LAST-1:0], keycode_i};
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            irq_sync <= '0;
            irq_prev <= 1'b0;
        end
        else begin
            irq_sync <= {irq_sync[LAST-1:0], keyboard_irq_i};
            irq_prev <= irq_sync[LAST];
        end
    end

    assign irq_rise = irq_sync[LAST] & ~irq_prev;

    always_ff @(posedge clock) begin
        if (reset) begin
            keycode_q   <= '0;
            interrupt_q <= 1'b0;
        end
        else if (clear_i) begin
            // Last code stays readable while the request is dropped
            interrupt_q <= 1'b0;
        end
        else if (irq_rise) begin
            keycode_q   <= code_sync[LAST];
            interrupt_q <= 1'b1;
        end
    end

    assign keycode_o   = keycode_q;
    assign interrupt_o = interrupt_q;

endmodule

`default_nettype wire

// File: source/xt_peripherals_top.sv
// XT peripherals top level
// Connects bus decode, system RAM, BIOS ROM, port B and the keyboard latch

`timescale 1ns/10ps
`default_nettype none

module xt_peripherals_top (
    input  wire logic                              clock,
    input  wire logic                              reset,
    // CPU bus
    input  wire logic [xt_map_pkg::ADDR_W-1:0]     address_i,
    input  wire logic [xt_map_pkg::DATA_W-1:0]     data_i,
    input  wire logic                              io_read_n_i,
    input  wire logic                              io_write_n_i,
    input  wire logic                              memory_read_n_i,
    input  wire logic                              memory_write_n_i,
    input  wire logic                              address_enable_n_i,
    output logic      [xt_map_pkg::DATA_W-1:0]     data_bus_out_o,
    output logic                                   data_bus_out_from_chipset_o,
    output logic                                   dma_chip_select_n_o,
    output logic                                   dma_page_chip_select_n_o,
    // BIOS download
    input  wire logic                              ioctl_download_i,
    input  wire logic                              ioctl_wr_i,
    input  wire logic [xt_dev_pkg::DL_ADDR_W-1:0]  ioctl_addr_i,
    input  wire logic [xt_map_pkg::DATA_W-1:0]     ioctl_data_i,
    // Keyboard and speaker
    input  wire logic [xt_map_pkg::DATA_W-1:0]     keycode_i,
    input  wire logic                              keyboard_irq_i,
    output logic                                   speaker_gate_o,
    output logic                                   speaker_data_o,
    output logic                                   keyboard_interrupt_o
);

    logic                          ram_write;
    logic                          rom_select;
    logic                          port_b_write;
    logic                          keyboard_clear;
    logic [xt_map_pkg::DATA_W-1:0] ram_data;
    logic [xt_map_pkg::DATA_W-1:0] rom_data;
    logic [xt_map_pkg::DATA_W-1:0] port_b;
    logic [xt_map_pkg::DATA_W-1:0] keycode_latched;

    xt_bus_control u_bus_control (
        .address_i                   (address_i),
        .io_read_n_i                 (io_read_n_i),
        .io_write_n_i                (io_write_n_i),
        .memory_read_n_i             (memory_read_n_i),
        .memory_write_n_i            (memory_write_n_i),
        .address_enable_n_i          (address_enable_n_i),
        .ram_data_i                  (ram_data),
        .rom_data_i                  (rom_data),
        .port_b_i                    (port_b),
        .keycode_i                   (keycode_latched),
        .ram_write_o                 (ram_write),
        .rom_select_o                (rom_select),
        .port_b_write_o              (port_b_write),
        .dma_chip_select_n_o         (dma_chip_select_n_o),
        .dma_page_chip_select_n_o    (dma_page_chip_select_n_o),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

    xt_system_ram u_system_ram (
        .clock     (clock),
        .write_i   (ram_write),
        .address_i (address_i[xt_dev_pkg::RAM_ADDR_W-1:0]),
        .data_i    (data_i),
        .data_o    (ram_data)
    );

    xt_bios_rom u_bios_rom (
        .clock            (clock),
        .select_i         (rom_select),
        .address_i        (address_i[xt_dev_pkg::ROM_ADDR_W-1:0]),
        .ioctl_download_i (ioctl_download_i),
        .ioctl_wr_i       (ioctl_wr_i),
        .ioctl_addr_i     (ioctl_addr_i),
        .ioctl_data_i     (ioctl_data_i),
        .data_o           (rom_data)
    );

    xt_system_port u_system_port (
        .clock            (clock),
        .reset            (reset),
        .write_i          (port_b_write),
        .data_i           (data_i),
        .port_b_o         (port_b),
        .speaker_gate_o   (speaker_gate_o),
        .speaker_data_o   (speaker_data_o),
        .keyboard_clear_o (keyboard_clear)
    );

    xt_keyboard_latch u_keyboard_latch (
        .clock          (clock),
        .reset          (reset),
        .keycode_i      (keycode_i),
        .keyboard_irq_i (keyboard_irq_i),
        .clear_i        (keyboard_clear),
        .keycode_o      (keycode_latched),
        .interrupt_o    (keyboard_interrupt_o)
    );

endmodule

`default_nettype wire

// File: verification/tb_xt_model.svh
// Reference model of the XT peripherals block
// Tracks RAM and ROM contents, port B and the keyboard latch from the
// address map and port rules, and predicts every chipset read

`ifndef TB_XT_MODEL_SVH
`define TB_XT_MODEL_SVH

logic [7:0] ram_model [logic [17:0]];
logic [7:0] rom_model [logic [15:0]];
logic [7:0] port_b_model;
logic [7:0] keycode_model;
logic       interrupt_model;

function automatic void model_reset();
    port_b_model    = 8'h00;
    keycode_model   = 8'h00;
    interrupt_model = 1'b0;
endfunction

// Bit 7 of port B holds the keyboard interrupt in clear
function automatic void model_port_b_write(input logic [7:0] value);
    port_b_model = value;
    if (value[7]) begin
        interrupt_model = 1'b0;
    end
endfunction

// A request is dropped while the clear bit is set
function automatic void model_key_request(input logic [7:0] code);
    if (!port_b_model[7]) begin
        keycode_model   = code;
        interrupt_model = 1'b1;
    end
endfunction

// RAM answers regions 0-3, the BIOS region F, nothing else
task automatic model_mem_read(input logic [19:0] addr, output logic valid,
                              output logic [7:0] value);
    valid = 1'b1;
    value = 8'h00;
    if (addr[19:16] <= 4'd3) begin
        value = ram_model[addr[17:0]];
    end
    else if (addr[19:16] == 4'hF) begin
        value = rom_model[addr[15:0]];
    end
    else begin
        valid = 1'b0;
    end
endtask

// Ports 0x60-0x63 return the scan code, port B and two idle bytes
function automatic logic [7:0] model_ppi_read(input logic [1:0] reg_num);
    case (reg_num)
        2'd0:    return keycode_model;
        2'd1:    return port_b_model;
        default: return 8'hFF;
    endcase
endfunction

`endif

// File: verification/tb_xt_peripherals.sv
// Testbench for the XT peripherals block
// Drives LFSR-random bus, download and keyboard traffic and checks
// every response against the reference model

`timescale 1ns/10ps
`default_nettype none

module tb_xt_peripherals;

    // Active-low strobes as {io_read, io_write, memory_read, memory_write}
    localparam logic [3:0] IDLE   = 4'b1111;
    localparam logic [3:0] IO_RD  = 4'b0111;
    localparam logic [3:0] IO_WR  = 4'b1011;
    localparam logic [3:0] MEM_RD = 4'b1101;
    localparam logic [3:0] MEM_WR = 4'b1110;

    logic        clock;
    logic        reset;
    logic [19:0] address;
    logic [7:0]  data_in;
    logic [3:0]  strobes_n;
    logic        address_enable_n;
    logic        ioctl_download;
    logic        ioctl_wr;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic [7:0]  keycode;
    logic        keyboard_irq;
    logic [7:0]  data_out;
    logic        data_valid;
    logic        dma_select_n;
    logic        dma_page_select_n;
    logic        speaker_gate;
    logic        speaker_data;
    logic        keyboard_interrupt;
    logic [15:0] lfsr_state;
    logic [17:0] ram_addrs [$];
    logic [15:0] rom_offsets [$];

    `include "tb_xt_model.svh"

    xt_peripherals_top dut0 (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data_in),
        .io_read_n_i                 (strobes_n[3]),
        .io_write_n_i                (strobes_n[2]),
        .memory_read_n_i             (strobes_n[1]),
        .memory_write_n_i            (strobes_n[0]),
        .address_enable_n_i          (address_enable_n),
        .data_bus_out_o              (data_out),
        .data_bus_out_from_chipset_o (data_valid),
        .dma_chip_select_n_o         (dma_select_n),
        .dma_page_chip_select_n_o    (dma_page_select_n),
        .ioctl_download_i            (ioctl_download),
        .ioctl_wr_i                  (ioctl_wr),
        .ioctl_addr_i                (ioctl_addr),
        .ioctl_data_i                (ioctl_data),
        .keycode_i                   (keycode),
        .keyboard_irq_i              (keyboard_irq),
        .speaker_gate_o              (speaker_gate),
        .speaker_data_o              (speaker_data),
        .keyboard_interrupt_o        (keyboard_interrupt)
    );

    always #50 clock = ~clock;

    // 16-bit Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_byte(input logic [7:0] actual, input logic [7:0] expected,
                              input string what);
        assert (actual === expected) else begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        assert (actual === expected) else begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Holds address and strobe for two cycles and returns in the second one
    task automatic hold_access(input logic [19:0] addr, input logic [7:0] value,
                               input logic [3:0] strobes, input logic aen_n);
        @(posedge clock);
        address          <= addr;
        data_in          <= value;
        strobes_n        <= strobes;
        address_enable_n <= aen_n;
        @(negedge clock);
        @(negedge clock);
    endtask

    task automatic end_access();
        @(posedge clock);
        strobes_n        <= IDLE;
        address_enable_n <= 1'b1;
        @(negedge clock);
    endtask

    task automatic bus_write(input logic [19:0] addr, input logic [7:0] value,
                             input logic [3:0] strobes);
        hold_access(addr, value, strobes, 1'b0);
        end_access();
    endtask

    task automatic check_mem_read(input logic [19:0] addr);
        logic       valid;
        logic [7:0] value;
        model_mem_read(addr, valid, value);
        hold_access(addr, 8'h00, MEM_RD, 1'b0);
        check_flag(data_valid, valid, $sformatf("chipset flag at %05h", addr));
        check_byte(data_out, value, $sformatf("memory data at %05h", addr));
        end_access();
    endtask

    task automatic check_io_read(input logic [7:0] port);
        hold_access({12'h000, port}, 8'h00, IO_RD, 1'b0);
        check_flag(data_valid, 1'b1, $sformatf("chipset flag at port %02h", port));
        check_byte(data_out, model_ppi_read(port[1:0]), $sformatf("port %02h", port));
        end_access();
    endtask

    task automatic check_dma_select(input logic [7:0] port, input logic aen_n,
                                    input logic dma_n, input logic page_n);
        hold_access({12'h000, port}, 8'h00, IO_RD, aen_n);
        check_flag(dma_select_n, dma_n, $sformatf("DMA select at port %02h", port));
        check_flag(dma_page_select_n, page_n, $sformatf("DMA page select at %02h", port));
        end_access();
    endtask

    task automatic download_rom(input int count);
        logic [31:0] r;
        @(posedge clock);
        ioctl_download <= 1'b1;
        for (int i = 0; i < count; i++) begin
            r = random_bits(24);
            rom_model[r[23:8]] = r[7:0];
            rom_offsets.push_back(r[23:8]);
            @(posedge clock);
            ioctl_wr   <= 1'b1;
            ioctl_addr <= {9'd0, r[23:8]};
            ioctl_data <= r[7:0];
        end
        @(posedge clock);
        ioctl_wr       <= 1'b0;
        ioctl_download <= 1'b0;
    endtask

    task automatic key_request(input logic [7:0] code);
        model_key_request(code);
        @(posedge clock);
        keycode <= code;
        @(posedge clock);
        keyboard_irq <= 1'b1;
    endtask

    // Low level must pass the synchronizer before the next edge
    task automatic drop_request();
        @(posedge clock);
        keyboard_irq <= 1'b0;
        repeat (4) @(posedge clock);
    endtask

    task automatic wait_for_interrupt(input int max_cycles);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (keyboard_interrupt !== 1'b1) begin
            if (cycles >= max_cycles) begin
                $display("Keyboard interrupt did not rise within %0d cycles", max_cycles);
                abort_run();
            end
            cycles++;
            @(negedge clock);
        end
    endtask

    initial begin
        logic [31:0] r;
        clock            = 1'b0;
        reset            = 1'b1;
        address          = '0;
        data_in          = '0;
        strobes_n        = IDLE;
        address_enable_n = 1'b1;
        ioctl_download   = 1'b0;
        ioctl_wr         = 1'b0;
        ioctl_addr       = '0;
        ioctl_data       = '0;
        keycode          = '0;
        keyboard_irq     = 1'b0;
        lfsr_state       = 16'd34;
        model_reset();
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);

        check_flag(dma_select_n, 1'b1, "DMA select after reset");
        check_flag(dma_page_select_n, 1'b1, "DMA page select after reset");
        check_flag(keyboard_interrupt, 1'b0, "keyboard interrupt after reset");
        check_flag(speaker_gate, 1'b0, "speaker gate after reset");
        check_flag(speaker_data, 1'b0, "speaker data after reset");
        check_io_read(8'h61);

        // System RAM, then unmapped regions 4-B
        repeat (24) begin
            r = random_bits(26);
            ram_model[r[25:8]] = r[7:0];
            ram_addrs.push_back(r[25:8]);
            bus_write({2'b00, r[25:8]}, r[7:0], MEM_WR);
        end
        foreach (ram_addrs[i]) begin
            check_mem_read({2'b00, ram_addrs[i]});
        end
        repeat (8) begin
            r = random_bits(19);
            check_mem_read({4'h4 + {1'b0, r[18:16]}, r[15:0]});
        end

        // BIOS download followed by CPU writes that must not land
        download_rom(16);
        foreach (rom_offsets[i]) begin
            r = random_bits(8);
            bus_write({4'hF, rom_offsets[i]}, r[7:0], MEM_WR);
        end
        foreach (rom_offsets[i]) begin
            check_mem_read({4'hF, rom_offsets[i]});
        end

        repeat (8) begin
            r = random_bits(8);
            model_port_b_write(r[7:0]);
            bus_write(20'h00061, r[7:0], IO_WR);
            check_io_read(8'h61);
            check_flag(speaker_gate, port_b_model[0], "speaker gate");
            check_flag(speaker_data, port_b_model[1], "speaker data");
        end
        check_io_read(8'h62);
        check_io_read(8'h63);

        repeat (4) begin
            r = random_bits(5);
            check_dma_select({3'd0, r[4:0]}, 1'b0, 1'b0, 1'b1);
            check_dma_select({3'd0, r[4:0]}, 1'b1, 1'b1, 1'b1);
            check_dma_select({3'd4, r[4:0]}, 1'b0, 1'b1, 1'b0);
            check_dma_select({3'd4, r[4:0]}, 1'b1, 1'b1, 1'b1);
        end

        // Keyboard request with the latch enabled
        model_port_b_write(8'h00);
        bus_write(20'h00061, 8'h00, IO_WR);
        r = random_bits(8);
        key_request(r[7:0]);
        wait_for_interrupt(12);
        check_io_read(8'h60);
        drop_request();

        // Clear bit drops the interrupt and blocks new codes
        model_port_b_write(8'h80);
        bus_write(20'h00061, 8'h80, IO_WR);
        check_flag(keyboard_interrupt, interrupt_model, "interrupt after clear");
        r = random_bits(8);
        key_request(r[7:0]);
        repeat (6) begin
            @(negedge clock);
            check_flag(keyboard_interrupt, 1'b0, "interrupt while cleared");
        end
        check_io_read(8'h60);
        drop_request();

        model_port_b_write(8'h00);
        bus_write(20'h00061, 8'h00, IO_WR);
        r = random_bits(8);
        key_request(r[7:0]);
        wait_for_interrupt(12);
        check_io_read(8'h60);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verification
source/xt_map_pkg.sv
source/xt_dev_pkg.sv
source/xt_bus_control.sv
source/xt_system_ram.sv
source/xt_bios_rom.sv
source/xt_system_port.sv
source/xt_keyboard_latch.sv
source/xt_peripherals_top.sv
verification/tb_xt_peripherals.sv

// File: Makefile
# Verilator simulation of the XT peripherals block

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f filelist.f \
		--top-module tb_xt_peripherals -Mdir obj_dir -o sim_xt
	./obj_dir/sim_xt > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
